/* build.f */
rtl/cpuCtrlPkg.sv
rtl/conditionEval.sv
rtl/fetchSequencer.sv
rtl/instructionDecoder.sv
rtl/controller.sv
tests/controller_props.sv
tests/controllerChecker.sv
tests/controllerTb.sv

/* Makefile */
# Verilator build for the controller testbench
VERILATOR ?= verilator
TOP       ?= controllerTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

/* tests/controllerTb.sv */
`timescale 1ns/10ps
`default_nettype none

module controllerTb
	import cpuCtrlPkg::*;
();

	localparam int ClkPeriod   = 100;
	localparam int DriveDelay  = 2;   // After the rising edge
	localparam int ResetCycles = 16;
	localparam int NumInstr    = 324; // Sum over all tests below
	localparam int CycleLimit  = 2 * NumInstr + ResetCycles + 20;

	localparam logic [3:0] ImmOps [9] =
		'{4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd9, 4'd11, 4'd13, 4'd15};
	localparam logic [3:0] RegExts [8] = '{4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd9, 4'd11, 4'd13};
	localparam logic [3:0] BadOps [4] = '{4'd7, 4'd8, 4'd10, 4'd14};

	logic       clk = 1'b0;
	logic       rst;
	instWord_t  instruction;
	psr_t       psrIn;
	memStrobe_t mem;
	dpCtrl_t    ctrl;
	int         errorCount;
	int         checkCount;
	int         cycles = 0;
	int         testStart;  // Error count when the current test began
	int         assertFails;

	always #(ClkPeriod / 2) clk = ~clk;

	controller controller_inst (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.psrIn       (psrIn),
		.mem         (mem),
		.ctrl        (ctrl)
	);

	controllerChecker resultCheck (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.psrIn       (psrIn),
		.mem         (mem),
		.ctrl        (ctrl),
		.errorCount  (errorCount),
		.checkCount  (checkCount)
	);

	bind controller controller_props controllerProps (
		.clk      (clk),
		.rst      (rst),
		.decoding (decoding),
		.inst     (inst),
		.mem      (mem),
		.ctrl     (ctrl)
	);

	function automatic instWord_t iWord(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
		return instWord_t'({op, rd, imm});
	endfunction

	function automatic instWord_t rWord(logic [3:0] op, logic [3:0] rd, logic [3:0] ext,
		logic [3:0] rs);
		return instWord_t'({op, rd, ext, rs});
	endfunction

	function automatic logic [3:0] rand4();
		return 4'($urandom);
	endfunction

	// One instruction over FETCH and DECODE with fresh flags each cycle
	task automatic issue(input instWord_t word);
		instruction = word;
		psrIn = psr_t'(5'($urandom));
		@(posedge clk);
		#DriveDelay;
		instruction = instWord_t'(16'($urandom)); // Ignored while decoding
		psrIn = psr_t'(5'($urandom));
		@(posedge clk);
		#DriveDelay;
	endtask

	task automatic endTest(input string name, input int count);
		$display("Test %s: %0d instructions, %0d errors", name, count, errorCount - testStart);
		testStart = errorCount;
	endtask

	////////////////////////////////////////
	// Timeout
	////////////////////////////////////////

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", CycleLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		void'($urandom(7507));
		rst = 1'b0;
		instruction = '0;
		psrIn = '0;
		testStart = 0;
		repeat (ResetCycles) @(posedge clk);
		#DriveDelay;
		rst = 1'b1; // Current cycle is FETCH

		repeat (8) issue(instWord_t'(16'($urandom)));
		endTest("resetFetch", 8);

		for (int i = 0; i < 9; i++)
			repeat (4)
			begin
				issue(iWord(ImmOps[i], rand4(), 8'($urandom)));
				issue(rWord(4'd4, rand4(), 4'd3, rand4())); // SCOND reads the new flags
			end
		endTest("immAlu", 72);

		for (int i = 0; i < 8; i++)
			repeat (4)
			begin
				issue(rWord(4'd0, rand4(), RegExts[i], rand4()));
				issue(rWord(4'd4, rand4(), 4'd12, rand4())); // JCOND
			end
		endTest("regAlu", 64);

		repeat (8)
		begin
			issue(rWord(4'd4, rand4(), 4'd0, rand4()));
			issue(rWord(4'd4, rand4(), 4'd4, rand4()));
		end
		endTest("loadStore", 16);

		// Kind 0 SCOND, 1 BCOND, 2 JCOND
		for (int code = 0; code < 16; code++)
			for (int kind = 0; kind < 3; kind++)
			begin
				issue(iWord(4'd5, rand4(), 8'($urandom)));
				issue(rWord(4'd4, rand4(), 4'(kind * 4), rand4())); // LOAD, STOR or JAL keeps flags
				if (kind == 0)
					issue(rWord(4'd4, rand4(), 4'd3, 4'(code)));
				else if (kind == 1)
					issue(iWord(4'd12, rand4(), {rand4(), 4'(code)}));
				else
					issue(rWord(4'd4, 4'(code), 4'd12, rand4()));
			end
		endTest("conditions", 144);

		repeat (4) issue(rWord(4'd4, rand4(), 4'd8, rand4()));
		for (int i = 0; i < 4; i++)
		begin
			issue(iWord(BadOps[i], rand4(), 8'($urandom)));
			issue(iWord(BadOps[i], rand4(), 8'($urandom)));
			issue(rWord(4'd0, rand4(), 4'(i * 4), rand4()));     // 0 4 8 12 unused here
			issue(rWord(4'd4, rand4(), 4'(i * 4 + 1), rand4())); // 1 5 9 13 unused here
		end
		endTest("jalUnknown", 20);

		assertFails = controller_inst.controllerProps.failures;
		$display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/controllerChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module controllerChecker
	import cpuCtrlPkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire instWord_t  instruction,
	input  wire psr_t       psrIn,
	input  wire memStrobe_t mem,
	input  wire dpCtrl_t    ctrl,
	output int              errorCount,
	output int              checkCount
);

	typedef struct packed {
		memStrobe_t mem;
		dpCtrl_t    ctrl;
		logic       psrEn;
	} expect_t;

	logic      phase;   // High in DECODE
	instWord_t latched;
	psr_t      flags;
	expect_t   want;

	function automatic logic condHolds(logic [3:0] code, psr_t p);
		case (code)
			4'd0, 4'd1:   return p.z ^ code[0]; // Odd codes invert
			4'd2, 4'd3:   return p.c ^ code[0];
			4'd4, 4'd5:   return p.l ^ code[0];
			4'd6, 4'd7:   return p.n ^ code[0];
			4'd8, 4'd9:   return p.f ^ code[0];
			4'd10, 4'd11: return (p.z | p.l) ^ !code[0];
			4'd12, 4'd13: return (p.z | p.n) ^ !code[0];
			4'd14:        return 1'b1;
			default:      return 1'b0;
		endcase
	endfunction

	////////////////////////////////////////
	// Reference decode
	////////////////////////////////////////

	function automatic expect_t expected(logic dec, instWord_t w, psr_t p);
		expect_t    e;
		logic [3:0] op;
		logic [3:0] ext;
		aluOp_t     alu;
		op = w[15:12];
		ext = w[7:4];
		e.mem = '{sramCe: 1'b1, sramOe: 1'b1, sramWe: 1'b1, romCe: dec, romOe: dec};
		e.ctrl = '0;
		e.ctrl.wbSel = WB_ALU;
		e.psrEn = 1'b0;
		if (!dec)
			return e;
		// Immediate and register ALU share one op table keyed by opcode or ext
		case ((op == 4'd0) ? ext : op)
			4'd1:    alu = ALU_AND;
			4'd2:    alu = ALU_OR;
			4'd3:    alu = ALU_XOR;
			4'd5:    alu = ALU_ADD;
			4'd6:    alu = ALU_ADDU;
			4'd9:    alu = ALU_SUB;
			4'd11:   alu = ALU_SUB; // Compare
			4'd13:   alu = ALU_MOV;
			4'd15:   alu = (op == 4'd0) ? ALU_NOP : ALU_LUI;
			default: alu = ALU_NOP;
		endcase
		if (op != 4'd4 && op != 4'd12 && alu != ALU_NOP)
		begin
			e.ctrl.rDst = w[11:8];
			e.ctrl.aluOp = alu;
			e.ctrl.write = ((op == 4'd0) ? ext : op) != 4'd11;
			e.ctrl.pcEn = 1'b1;
			e.psrEn = 1'b1;
			if (op == 4'd0)
				e.ctrl.rSrc = w[3:0];
			else
			begin
				e.ctrl.immVal = w[7:0];
				e.ctrl.immMux = 1'b1;
			end
		end
		else if (op == 4'd12)
		begin
			e.ctrl.immVal = w[7:0];
			e.ctrl.immMux = 1'b1;
			e.ctrl.branch = condHolds(w[3:0], p);
			e.ctrl.pcEn = 1'b1;
		end
		else if (op == 4'd4 && ext inside {4'd0, 4'd3, 4'd4, 4'd8, 4'd12})
		begin
			e.ctrl.pcEn = 1'b1;
			if (ext != 4'd3)
				e.ctrl.rSrc = w[3:0];
			if (ext == 4'd0 || ext == 4'd4)
			begin
				e.ctrl.rDst = w[11:8];
				e.ctrl.memcMux = 1'b1;
				e.mem.sramCe = 1'b0;
				e.mem.sramOe = 1'b0;
				e.mem.sramWe = (ext == 4'd0);   // Store only
				e.ctrl.write = (ext == 4'd0);
				e.ctrl.wbSel = (ext == 4'd0) ? WB_MEM : WB_ALU;
			end
			else if (ext == 4'd3)
			begin
				e.ctrl.write = 1'b1;
				e.ctrl.wbSel = WB_COND;
				e.ctrl.condRslt = condHolds(w[3:0], p);
			end
			else if (ext == 4'd12)
				e.ctrl.jump = condHolds(w[11:8], p); // Code sits in rDst
			else
			begin
				e.ctrl.rDst = 4'd15;
				e.ctrl.jump = 1'b1;
				e.ctrl.write = 1'b1;
				e.ctrl.wbSel = WB_LINK;
			end
		end
		return e;
	endfunction

	assign want = expected(phase, latched, flags);

	// Mirror of the phase, instruction latch and status latch
	always @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			phase <= 1'b0;
			latched <= '0;
			flags <= '0;
		end
		else
		begin
			if (!phase)
				latched <= instruction;
			else if (want.psrEn)
				flags <= psrIn;
			phase <= !phase;
		end
	end

	task automatic checkField(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
		if (expVal !== actVal)
		begin
			errorCount++;
			$display("FAILED at %0t: %s expected 'h%0h got 'h%0h", $time, name, expVal, actVal);
		end
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
	end

	// Outputs are settled by the falling edge
	always @(negedge clk)
	begin
		checkCount++;
		checkField("mem", 32'(want.mem), 32'(mem));
		checkField("branch", 32'(want.ctrl.branch), 32'(ctrl.branch));
		checkField("jump", 32'(want.ctrl.jump), 32'(ctrl.jump));
		checkField("immMux", 32'(want.ctrl.immMux), 32'(ctrl.immMux));
		checkField("memcMux", 32'(want.ctrl.memcMux), 32'(ctrl.memcMux));
		checkField("pcEn", 32'(want.ctrl.pcEn), 32'(ctrl.pcEn));
		checkField("write", 32'(want.ctrl.write), 32'(ctrl.write));
		checkField("condRslt", 32'(want.ctrl.condRslt), 32'(ctrl.condRslt));
		checkField("wbSel", 32'(want.ctrl.wbSel), 32'(ctrl.wbSel));
		checkField("rDst", 32'(want.ctrl.rDst), 32'(ctrl.rDst));
		checkField("rSrc", 32'(want.ctrl.rSrc), 32'(ctrl.rSrc));
		checkField("immVal", 32'(want.ctrl.immVal), 32'(ctrl.immVal));
		checkField("aluOp", 32'(want.ctrl.aluOp), 32'(ctrl.aluOp));
	end

endmodule

`default_nettype wire

/* tests/controller_props.sv */
`timescale 1ns/10ps
`default_nettype none

module controller_props
	import cpuCtrlPkg::*;
(
	input wire             clk,
	input wire             rst,
	input wire             decoding,
	input wire instWord_t  inst,
	input wire memStrobe_t mem,
	input wire dpCtrl_t    ctrl
);

	int failures = 0; // Failed assertion count

	// Opcode and extension pairs that the decoder knows
	function automatic logic inTable(instWord_t w);
		case (w.rForm.opcode)
			OP_RTYPE:
				return w.rForm.ext inside {4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd9, 4'd11, 4'd13};
			OP_OTYPE:
				return w.rForm.ext inside {4'd0, 4'd3, 4'd4, 4'd8, 4'd12};
			default:
				return w.rForm.opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_ADDUI,
					OP_SUBI, OP_CMPI, OP_BCOND, OP_MOVI, OP_LUI};
		endcase
	endfunction

	// ROM enabled in FETCH only, and the phase flips every cycle
	romPhase: assert property (@(posedge clk) disable iff (!rst)
		$past(rst) |-> mem.romCe == decoding && decoding != $past(decoding))
		else
		begin
			failures++;
			$error("ROM enable out of step with the decode phase");
		end

	writeNeedsSelect: assert property (@(posedge clk) disable iff (!rst)
		!mem.sramWe |-> !mem.sramCe)
		else
		begin
			failures++;
			$error("SRAM write strobe without chip enable");
		end

	oneRedirect: assert property (@(posedge clk) disable iff (!rst)
		!(ctrl.jump && ctrl.branch))
		else
		begin
			failures++;
			$error("Jump and branch raised together");
		end

	pcAdvance: assert property (@(posedge clk) disable iff (!rst)
		decoding && inTable(inst) |-> ctrl.pcEn)
		else
		begin
			failures++;
			$error("Known instruction decoded without PC enable");
		end

endmodule

`default_nettype wire

/* rtl/controller.sv */
`timescale 1ns/10ps
`default_nettype none

module controller
	import cpuCtrlPkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire instWord_t instruction, // ROM data
	input  wire psr_t      psrIn,       // ALU flags
	output memStrobe_t     mem,
	output dpCtrl_t        ctrl
);

	////////////////////////////////////////
	// Sequencer to decoder
	////////////////////////////////////////

	logic      decoding;
	instWord_t inst;    // Latched word
	psr_t      psr;     // Latched flags
	logic      psrEn;

	fetchSequencer sequencer (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.psrIn       (psrIn),
		.psrEn       (psrEn),
		.decoding    (decoding),
		.inst        (inst),
		.psr         (psr)
	);

	// Combinational controls for the datapath
	instructionDecoder decoder (
		.decoding (decoding),
		.inst     (inst),
		.psr      (psr),
		.mem      (mem),
		.ctrl     (ctrl),
		.psrEn    (psrEn)
	);

endmodule

`default_nettype wire

/* rtl/instructionDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder
	import cpuCtrlPkg::*;
(
	input  wire            decoding,
	input  wire instWord_t inst,
	input  wire psr_t      psr,
	output memStrobe_t     mem,
	output dpCtrl_t        ctrl,
	output logic           psrEn
);

	cond_t  condCode;
	logic   condTrue;
	aluOp_t regOp;

	////////////////////////////////////////
	// ALU op lookup
	////////////////////////////////////////

	function automatic aluOp_t immAluOp(opcode_t op);
		case (op)
			OP_ADDI:  return ALU_ADD;
			OP_ADDUI: return ALU_ADDU;
			OP_SUBI:  return ALU_SUB;
			OP_CMPI:  return ALU_SUB; // Compare is a subtract without writeback
			OP_ANDI:  return ALU_AND;
			OP_ORI:   return ALU_OR;
			OP_XORI:  return ALU_XOR;
			OP_MOVI:  return ALU_MOV;
			OP_LUI:   return ALU_LUI;
			default:  return ALU_NOP;
		endcase
	endfunction

	function automatic aluOp_t regAluOp(logic [ExtWidth-1:0] ext);
		case (ext)
			R_ADD:   return ALU_ADD;
			R_ADDU:  return ALU_ADDU;
			R_SUB:   return ALU_SUB;
			R_CMP:   return ALU_SUB;
			R_AND:   return ALU_AND;
			R_OR:    return ALU_OR;
			R_XOR:   return ALU_XOR;
			R_MOV:   return ALU_MOV;
			default: return ALU_NOP; // Unknown extension
		endcase
	endfunction

	assign regOp = regAluOp(inst.rForm.ext);

	// JCOND keeps its condition in the rDst slot
	assign condCode = (inst.rForm.opcode == OP_OTYPE && inst.rForm.ext == O_JCOND)
		? cond_t'(inst.rForm.rDst)
		: cond_t'(inst.rForm.rSrc);

	conditionEval condEval (
		.code     (condCode),
		.psr      (psr),
		.condTrue (condTrue)
	);

	////////////////////////////////////////
	// Control decode
	////////////////////////////////////////

	always_comb
	begin
		// FETCH defaults, ROM enabled only while not decoding
		mem = '{sramCe: 1'b1, sramOe: 1'b1, sramWe: 1'b1, romCe: decoding, romOe: decoding};
		ctrl = '0;
		ctrl.wbSel = WB_ALU;
		psrEn = 1'b0;

		if (decoding)
		begin
			case (inst.iForm.opcode)
				OP_ADDI, OP_ADDUI, OP_SUBI, OP_CMPI, OP_ANDI,
				OP_ORI, OP_XORI, OP_MOVI, OP_LUI:
				begin
					ctrl.rDst = inst.iForm.rDst;
					ctrl.immVal = inst.iForm.imm;
					ctrl.immMux = 1'b1;
					ctrl.aluOp = immAluOp(inst.iForm.opcode);
					ctrl.write = (inst.iForm.opcode != OP_CMPI);
					ctrl.pcEn = 1'b1;
					psrEn = 1'b1;
				end

				OP_RTYPE:
					if (regOp != ALU_NOP)
					begin
						ctrl.rDst = inst.rForm.rDst;
						ctrl.rSrc = inst.rForm.rSrc;
						ctrl.aluOp = regOp;
						ctrl.write = (inst.rForm.ext != R_CMP);
						ctrl.pcEn = 1'b1;
						psrEn = 1'b1;
					end

				OP_OTYPE:
					case (inst.rForm.ext)
						O_LOAD:
						begin
							ctrl.rDst = inst.rForm.rDst;
							ctrl.rSrc = inst.rForm.rSrc; // Address register
							ctrl.memcMux = 1'b1;
							ctrl.write = 1'b1;
							ctrl.wbSel = WB_MEM;
							ctrl.pcEn = 1'b1;
							mem.sramCe = 1'b0;
							mem.sramOe = 1'b0;
						end
						O_STOR:
						begin
							ctrl.rDst = inst.rForm.rDst;
							ctrl.rSrc = inst.rForm.rSrc;
							ctrl.memcMux = 1'b1;
							ctrl.pcEn = 1'b1;
							mem.sramCe = 1'b0;
							mem.sramOe = 1'b0;
							mem.sramWe = 1'b0;
						end
						O_SCOND:
						begin
							ctrl.write = 1'b1;
							ctrl.wbSel = WB_COND;
							ctrl.condRslt = condTrue;
							ctrl.pcEn = 1'b1;
						end
						O_JCOND:
						begin
							ctrl.rSrc = inst.rForm.rSrc; // Jump target register
							ctrl.jump = condTrue;
							ctrl.pcEn = 1'b1;
						end
						O_JAL:
						begin
							ctrl.rDst = LinkReg;
							ctrl.rSrc = inst.rForm.rSrc;
							ctrl.jump = 1'b1;
							ctrl.write = 1'b1;
							ctrl.wbSel = WB_LINK;
							ctrl.pcEn = 1'b1;
						end
						default: ; // Unknown extension keeps defaults
					endcase

				OP_BCOND:
				begin
					// Displacement rides on the immediate path
					ctrl.immVal = inst.iForm.imm;
					ctrl.immMux = 1'b1;
					ctrl.branch = condTrue;
					ctrl.pcEn = 1'b1;
				end

				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/fetchSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchSequencer
	import cpuCtrlPkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire instWord_t instruction, // From ROM
	input  wire psr_t  psrIn,           // Flags from ALU
	input  wire        psrEn,
	output logic       decoding,
	output instWord_t  inst,
	output psr_t       psr
);

	typedef enum logic {
		FETCH  = 1'b0,
		DECODE = 1'b1
	} state_t;

	state_t state;

	////////////////////////////////////////
	// Two state sequencer
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= FETCH;
		else
			state <= (state == FETCH) ? DECODE : FETCH;
	end

	assign decoding = (state == DECODE);

	// Instruction latch, loaded on the edge that ends FETCH
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			inst <= '0;
		else if (state == FETCH)
			inst <= instruction;
	end

	// Flags only update after a flag setting instruction
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			psr <= '0;
		else if (state == DECODE && psrEn)
			psr <= psrIn;
	end

endmodule

`default_nettype wire

/* rtl/conditionEval.sv */
`timescale 1ns/10ps
`default_nettype none

module conditionEval
	import cpuCtrlPkg::*;
(
	input  wire cond_t code,
	input  wire psr_t  psr,
	output logic       condTrue
);

	always_comb
	begin
		case (code)
			C_EQ: condTrue = psr.z;
			C_NE: condTrue = !psr.z;
			C_CS: condTrue = psr.c;
			C_CC: condTrue = !psr.c;
			C_HI: condTrue = psr.l;
			C_LS: condTrue = !psr.l;
			C_GT: condTrue = psr.n;
			C_LE: condTrue = !psr.n;
			C_FS: condTrue = psr.f;
			C_FC: condTrue = !psr.f;

			// Or-ed forms and their complements
			C_HS: condTrue = psr.z | psr.l;
			C_LO: condTrue = !psr.z & !psr.l;
			C_GE: condTrue = psr.z | psr.n;
			C_LT: condTrue = !psr.z & !psr.n;

			C_UC: condTrue = 1'b1; // Unconditional
			C_NV: condTrue = 1'b0;
			default: condTrue = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/cpuCtrlPkg.sv */
`default_nettype none

package cpuCtrlPkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	localparam int DataWidth = 16; // Instruction word
	localparam int OpWidth   = 4;
	localparam int RegWidth  = 4;
	localparam int ExtWidth  = 4;
	localparam int ImmWidth  = DataWidth - OpWidth - RegWidth; // 8 bits

	// JAL return address goes here
	localparam logic [RegWidth-1:0] LinkReg = RegWidth'(15);

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// Major opcode, bits 15:12
	typedef enum logic [OpWidth-1:0] {
		OP_RTYPE = 4'd0,  OP_ANDI  = 4'd1,  OP_ORI  = 4'd2,  OP_XORI  = 4'd3,
		OP_OTYPE = 4'd4,  OP_ADDI  = 4'd5,  OP_ADDUI = 4'd6, OP_SUBI = 4'd9,
		OP_CMPI  = 4'd11, OP_BCOND = 4'd12, OP_MOVI = 4'd13, OP_LUI  = 4'd15
	} opcode_t;

	// Register ALU extension, bits 7:4 under OP_RTYPE
	typedef enum logic [ExtWidth-1:0] {
		R_AND = 4'd1, R_OR  = 4'd2, R_XOR  = 4'd3,  R_ADD = 4'd5,
		R_ADDU = 4'd6, R_SUB = 4'd9, R_CMP = 4'd11, R_MOV = 4'd13
	} rExt_t;

	// Memory and jump extension, bits 7:4 under OP_OTYPE
	typedef enum logic [ExtWidth-1:0] {
		O_LOAD = 4'd0, O_SCOND = 4'd3, O_STOR = 4'd4, O_JAL = 4'd8, O_JCOND = 4'd12
	} oExt_t;

	typedef enum logic [RegWidth-1:0] {
		C_EQ = 4'd0,  C_NE = 4'd1,  C_CS = 4'd2,  C_CC = 4'd3,
		C_HI = 4'd4,  C_LS = 4'd5,  C_GT = 4'd6,  C_LE = 4'd7,
		C_FS = 4'd8,  C_FC = 4'd9,  C_LO = 4'd10, C_HS = 4'd11,
		C_LT = 4'd12, C_GE = 4'd13, C_UC = 4'd14,
		C_NV = 4'd15  // Never true
	} cond_t;

	typedef enum logic [3:0] {
		ALU_NOP, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_AND,
		ALU_OR, ALU_XOR, ALU_MOV, ALU_LUI
	} aluOp_t;

	// Register file writeback source
	typedef enum logic [1:0] {
		WB_LINK = 2'd0, WB_COND = 2'd1, WB_ALU = 2'd2, WB_MEM = 2'd3
	} wbSel_t;

	////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////

	typedef struct packed {
		opcode_t               opcode;
		logic [RegWidth-1:0]   rDst;
		logic [ImmWidth-1:0]   imm;
	} iForm_t;

	// rSrc carries the condition code for SCOND and BCOND
	typedef struct packed {
		opcode_t               opcode;
		logic [RegWidth-1:0]   rDst;  // Condition code for JCOND
		logic [ExtWidth-1:0]   ext;
		logic [RegWidth-1:0]   rSrc;
	} rForm_t;

	typedef union packed {
		iForm_t iForm;
		rForm_t rForm;
	} instWord_t;

	////////////////////////////////////////
	// Status and control bundles
	////////////////////////////////////////

	typedef struct packed {
		logic c; // Carry
		logic l; // Low
		logic f; // Overflow
		logic z; // Zero
		logic n; // Negative
	} psr_t;

	// All active low
	typedef struct packed {
		logic sramCe;
		logic sramOe;
		logic sramWe;
		logic romCe;
		logic romOe;
	} memStrobe_t;

	typedef struct packed {
		logic                branch;
		logic                jump;
		logic                immMux;   // ALU operand B from immVal
		logic                memcMux;  // Memory controller address from register
		logic                pcEn;
		logic                write;    // Register file write enable
		logic                condRslt;
		wbSel_t              wbSel;
		logic [RegWidth-1:0] rDst;
		logic [RegWidth-1:0] rSrc;
		logic [ImmWidth-1:0] immVal;
		aluOp_t              aluOp;
	} dpCtrl_t;

endpackage

`default_nettype wire
